/* sources.f */
logic/imuPkg.sv
logic/i2cRequestIf.sv
logic/i2cTransactionEngine.sv
logic/sensorSequencer.sv
logic/imuInterface.sv
testbench/adxlSlaveModel.sv
testbench/imuInterface_properties.sv
testbench/imuInterfaceTb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module imuInterfaceTb \
    -f sources.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Regression passed$" sim.log \
    && echo "Simulation result: pass" \
    || { echo "Simulation result: fail"; exit 1; }

/* testbench/imuInterfaceTb.sv */
`timescale 1ns/1ps
`default_nettype none

module imuInterfaceTb;

    logic                COUNT;
    logic                reset_n;
    logic                mute;
    wire                 sdaBus;
    wire                 slaveRelease;
    logic                scl;
    logic                sdaLow;
    imuPkg::axisSample_t accelX;
    imuPkg::axisSample_t accelY;
    imuPkg::axisSample_t accelZ;
    logic                dataValid;

    int   seed = 355;
    int   errorCount = 0;
    int   timeoutCount = 0;
    logic ackPrev = 1'b0;

    assign sdaBus = ~sdaLow & slaveRelease;   // Open-drain wired-AND

    imuInterface i_imuInterface (
        .COUNT     (COUNT),
        .reset_n   (reset_n),
        .sdaIn     (sdaBus),
        .scl       (scl),
        .sdaLow    (sdaLow),
        .accelX    (accelX),
        .accelY    (accelY),
        .accelZ    (accelZ),
        .dataValid (dataValid)
    );

    adxlSlaveModel slave (.scl(scl), .sda(sdaBus), .mute(mute), .sdaRelease(slaveRelease));

    initial begin
        COUNT = 1'b0;
        forever #10 COUNT = ~COUNT;
    end

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            errorCount++;
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    function automatic imuPkg::axisSample_t assembleSample(input logic [7:0] low, high);
        return {high[4:0], low};
    endfunction

    task automatic fillDataRegisters();
        for (int i = 0; i < 6; i++) begin
            slave.regs[8'h32 + i] = 8'($random(seed));
        end
    endtask

    task automatic waitValid(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (dataValid !== level && cycles < 40000) begin
            @(negedge COUNT);
            cycles++;
        end
        if (dataValid !== level) begin
            timeoutCount++;
            $display("Timed out waiting for dataValid to %s", what);
        end
    endtask

    task automatic checkSamples(input string name);
        checkValue({name, " X"}, assembleSample(slave.regs[8'h32], slave.regs[8'h33]), accelX);
        checkValue({name, " Y"}, assembleSample(slave.regs[8'h34], slave.regs[8'h35]), accelY);
        checkValue({name, " Z"}, assembleSample(slave.regs[8'h36], slave.regs[8'h37]), accelZ);
    endtask

    task automatic checkStartupLog(input int first);
        checkValue("start-up write count", first + imuPkg::InitCount, slave.logCount);
        for (int i = 0; i < imuPkg::InitCount; i++) begin
            checkValue($sformatf("start-up reg %0d", first + i),
                       imuPkg::InitRegs[i], slave.logReg[first + i]);
            checkValue($sformatf("start-up data %0d", first + i),
                       imuPkg::InitData[i], slave.logData[first + i]);
        end
    endtask

    // Each transaction must hand back a released bus
    always @(negedge COUNT) begin
        if (i_imuInterface.requestBus.ack && !ackPrev) begin
            checkValue("bus released scl", 1, scl);
            checkValue("bus released sdaLow", 0, sdaLow);
        end
        ackPrev <= i_imuInterface.requestBus.ack;
    end

    initial begin
        int cycles;
        int propFails;
        reset_n <= 1'b0;
        mute    <= 1'b0;
        repeat (8) @(posedge COUNT);
        fillDataRegisters();
        reset_n <= 1'b1;
        @(negedge COUNT);
        checkValue("reset scl", 1, scl);
        checkValue("reset sdaLow", 0, sdaLow);
        checkValue("reset dataValid", 0, dataValid);
        checkValue("reset samples", 0, accelX | accelY | accelZ);

        for (int frame = 0; frame < 3; frame++) begin
            waitValid(1'b0, "fall");
            waitValid(1'b1, "rise");
            checkSamples($sformatf("frame %0d", frame));
            if (frame == 0) checkStartupLog(0);
            fillDataRegisters();
        end
        checkValue("no repeated start-up", imuPkg::InitCount, slave.logCount);

        // Mute the sensor in the middle of the next frame
        waitValid(1'b0, "fall before mute");
        @(posedge COUNT);
        mute <= 1'b1;
        cycles = 0;
        while (slave.nackCount == 0 && cycles < 20000) begin
            @(posedge COUNT);
            cycles++;
        end
        if (slave.nackCount == 0) begin
            timeoutCount++;
            $display("Timed out waiting for the muted sensor to refuse an acknowledge");
        end
        mute <= 1'b0;

        // Recovery goes back to the first start-up write before any publish
        cycles = 0;
        while (slave.logCount == imuPkg::InitCount && cycles < 20000) begin
            @(negedge COUNT);
            cycles++;
        end
        if (slave.logCount == imuPkg::InitCount) begin
            timeoutCount++;
            $display("Timed out waiting for the start-up writes to begin again");
        end
        checkValue("dataValid during recovery", 0, dataValid);
        waitValid(1'b1, "rise after recovery");
        checkStartupLog(imuPkg::InitCount);
        checkSamples("recovery frame");

        propFails = i_imuInterface.i_i2cTransactionEngine.props.failCount;
        $display("Closing: %0d check errors, %0d timeouts, %0d property failures",
                 errorCount, timeoutCount, propFails);
        if (errorCount == 0 && timeoutCount == 0 && propFails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/imuInterface_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module imuInterface_properties (
    input wire               COUNT,
    input wire               reset_n,
    input wire               req,
    input wire               ack,
    input wire               readNotWrite,
    input imuPkg::regByte_t  regAddr,
    input imuPkg::regByte_t  writeData,
    input wire               scl,
    input wire               sdaLow,
    input imuPkg::busPhase_e phase
);

    int failCount = 0;

    ackNeedsReq: assert property (@(posedge COUNT) disable iff (!reset_n)
        $rose(ack) |-> req)
        else begin $error("ack rose while req was low"); failCount++; end

    fieldsStable: assert property (@(posedge COUNT) disable iff (!reset_n)
        (req && $past(req)) |-> ($stable(regAddr) && $stable(writeData) && $stable(readNotWrite)))
        else begin $error("request fields changed while req was high"); failCount++; end

    // SDA may move under a high SCL only for start, repeated start and stop
    sdaWhileSclHigh: assert property (@(posedge COUNT) disable iff (!reset_n)
        (scl && $past(scl) && sdaLow != $past(sdaLow)) |->
            (phase inside {imuPkg::Start, imuPkg::RepStart, imuPkg::Stop}))
        else begin $error("sdaLow changed with scl high outside a bus condition"); failCount++; end

endmodule

bind i2cTransactionEngine imuInterface_properties props (
    .COUNT        (COUNT),
    .reset_n      (reset_n),
    .req          (bus.req),
    .ack          (bus.ack),
    .readNotWrite (bus.readNotWrite),
    .regAddr      (bus.regAddr),
    .writeData    (bus.writeData),
    .scl          (scl),
    .sdaLow       (sdaLow),
    .phase        (phase)
);

`default_nettype wire

/* testbench/adxlSlaveModel.sv */
`timescale 1ns/1ps
`default_nettype none

module adxlSlaveModel (
    input  wire  scl,
    input  wire  sda,          // Wired-AND bus level
    input  wire  mute,         // High withholds every acknowledge
    output logic sdaRelease    // Low pulls SDA down
);

    typedef enum {Idle, Address, Register, WriteData, ReadData, Ignore} slaveMode_e;

    slaveMode_e mode;
    int         bitCount;
    logic [7:0] shiftIn;
    logic [7:0] txByte;
    logic [7:0] regPointer;
    logic       ackNow;
    logic       prevScl;
    logic       prevSda;

    logic [7:0] regs [256];
    logic [7:0] logReg [64];   // Decoded writes, in bus order
    logic [7:0] logData [64];
    int         logCount;
    int         nackCount;

    initial begin
        sdaRelease = 1'b1;
        mode       = Idle;
        bitCount   = 0;
        regPointer = 8'h00;
        ackNow     = 1'b0;
        logCount   = 0;
        nackCount  = 0;
        prevScl    = 1'b1;
        prevSda    = 1'b1;
        for (int i = 0; i < 256; i++) begin
            regs[i] = 8'(i) ^ 8'h5A;
        end
    end

    // One process sees every bus edge and decides what it is
    always @(scl, sda) begin
        logic sclRise;
        logic sclFall;
        logic sdaRise;
        logic sdaFall;
        sclRise = (scl === 1'b1) && (prevScl === 1'b0);
        sclFall = (scl === 1'b0) && (prevScl === 1'b1);
        sdaRise = (sda === 1'b1) && (prevSda === 1'b0);
        sdaFall = (sda === 1'b0) && (prevSda === 1'b1);
        prevScl = scl;
        prevSda = sda;
        if (sdaFall && scl === 1'b1 && !sclRise) begin
            mode       = Address;   // Start or repeated start
            bitCount   = 0;
            sdaRelease = 1'b1;
        end else if (sdaRise && scl === 1'b1 && !sclRise) begin
            mode       = Idle;      // Stop
            bitCount   = 0;
            sdaRelease = 1'b1;
        end else if (sclRise) begin
            if (mode == ReadData) begin
                bitCount++;
            end else if (mode inside {Address, Register, WriteData} && bitCount < 8) begin
                shiftIn = {shiftIn[6:0], sda};
                bitCount++;
            end
        end else if (sclFall) begin
            if (mode == ReadData) begin
                sdaRelease = (bitCount < 8) ? txByte[7 - bitCount] : 1'b1;
            end else if (bitCount == 8) begin
                if (mode == Address) begin
                    ackNow = (shiftIn[7:1] == imuPkg::AccelAddr) && !mute;
                end else begin
                    ackNow = (mode inside {Register, WriteData}) && !mute;
                end
                if (!ackNow) nackCount++;
                sdaRelease = !ackNow;
                bitCount   = 9;   // Acknowledge clock
            end else if (bitCount == 9) begin
                sdaRelease = 1'b1;
                bitCount   = 0;
                if (!ackNow) begin
                    mode = Ignore;
                end else if (mode == Address) begin
                    if (shiftIn[0]) begin
                        mode       = ReadData;
                        txByte     = regs[regPointer];
                        sdaRelease = txByte[7];   // First data bit right away
                    end else begin
                        mode = Register;
                    end
                end else if (mode == Register) begin
                    regPointer = shiftIn;
                    mode       = WriteData;
                end else if (mode == WriteData) begin
                    regs[regPointer]  = shiftIn;
                    logReg[logCount]  = regPointer;
                    logData[logCount] = shiftIn;
                    logCount++;
                    regPointer++;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/imuInterface.sv */
`timescale 1ns/1ps
`default_nettype none

module imuInterface (
    input  wire                 COUNT,
    input  wire                 reset_n,
    input  wire                 sdaIn,      // Wired-AND bus level
    output logic                scl,        // High means released
    output logic                sdaLow,     // High pulls SDA low
    output imuPkg::axisSample_t accelX,
    output imuPkg::axisSample_t accelY,
    output imuPkg::axisSample_t accelZ,
    output logic                dataValid
);

    i2cRequestIf requestBus ();

    // Start-up table, axis read loop and sample assembly
    sensorSequencer i_sensorSequencer (
        .COUNT     (COUNT),
        .reset_n   (reset_n),
        .bus       (requestBus.requester),
        .accelX    (accelX),
        .accelY    (accelY),
        .accelZ    (accelZ),
        .dataValid (dataValid)
    );

    // Bit-level I2C, one register transaction per request
    i2cTransactionEngine i_i2cTransactionEngine (
        .COUNT   (COUNT),
        .reset_n (reset_n),
        .bus     (requestBus.engine),
        .sdaIn   (sdaIn),
        .scl     (scl),
        .sdaLow  (sdaLow)
    );

endmodule

`default_nettype wire

/* logic/sensorSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sensorSequencer (
    input  wire                   COUNT,
    input  wire                   reset_n,
    i2cRequestIf.requester        bus,
    output imuPkg::axisSample_t   accelX,
    output imuPkg::axisSample_t   accelY,
    output imuPkg::axisSample_t   accelZ,
    output logic                  dataValid
);

    typedef logic [$clog2(imuPkg::IdleGapCycles)-1:0] idleCount_t;

    imuPkg::seqState_e   state;
    logic [2:0]          initIndex;
    logic [2:0]          axisIndex;    // Position in AxisRegs
    idleCount_t          idleCount;
    imuPkg::regByte_t    lowShadow;
    imuPkg::axisSample_t pending [3];  // Samples of the frame in progress

    logic                handshakeDone;
    logic                readDone;

    assign handshakeDone = bus.req && bus.ack;
    assign readDone      = handshakeDone && !bus.nack && (state == imuPkg::ReadWait);

    // Low register is kept until its high register completes the sample
    always_ff @(posedge COUNT) begin
        if (readDone) begin
            if (!axisIndex[0]) begin
                lowShadow <= bus.readData;
            end else begin
                pending[axisIndex[2:1]] <= {bus.readData[4:0], lowShadow};
            end
        end
    end

    always_ff @(posedge COUNT) begin
        if (!reset_n) begin
            state            <= imuPkg::Init;
            initIndex        <= '0;
            axisIndex        <= '0;
            idleCount        <= '0;
            bus.req          <= 1'b0;
            bus.readNotWrite <= 1'b0;
            bus.regAddr      <= '0;
            bus.writeData    <= '0;
            accelX           <= '0;
            accelY           <= '0;
            accelZ           <= '0;
            dataValid        <= 1'b0;
        end else begin
            if (handshakeDone) bus.req <= 1'b0;

            if (handshakeDone && bus.nack) begin
                // Sensor stopped answering, start over from the table
                dataValid <= 1'b0;
                initIndex <= '0;
                state     <= imuPkg::Init;
            end else begin
                case (state)
                    imuPkg::Init: begin
                        if (!bus.ack) begin   // Previous handshake fully closed
                            bus.req          <= 1'b1;
                            bus.readNotWrite <= 1'b0;
                            bus.regAddr      <= imuPkg::InitRegs[initIndex];
                            bus.writeData    <= imuPkg::InitData[initIndex];
                            state            <= imuPkg::InitWait;
                        end
                    end

                    imuPkg::InitWait: begin
                        if (handshakeDone) begin
                            if (initIndex == 3'(imuPkg::InitCount - 1)) begin
                                initIndex <= '0;
                                axisIndex <= '0;
                                state     <= imuPkg::Read;
                            end else begin
                                initIndex <= initIndex + 1'b1;
                                state     <= imuPkg::Init;
                            end
                        end
                    end

                    imuPkg::Read: begin
                        if (!bus.ack) begin
                            bus.req          <= 1'b1;
                            bus.readNotWrite <= 1'b1;
                            bus.regAddr      <= imuPkg::AxisRegs[axisIndex];
                            dataValid        <= 1'b0;   // Falls with the first req of a frame
                            state            <= imuPkg::ReadWait;
                        end
                    end

                    imuPkg::ReadWait: begin
                        if (handshakeDone) begin
                            if (axisIndex == 3'($size(imuPkg::AxisRegs) - 1)) begin
                                state <= imuPkg::Publish;
                            end else begin
                                axisIndex <= axisIndex + 1'b1;
                                state     <= imuPkg::Read;
                            end
                        end
                    end

                    imuPkg::Publish: begin
                        accelX    <= pending[0];
                        accelY    <= pending[1];
                        accelZ    <= pending[2];
                        dataValid <= 1'b1;
                        idleCount <= '0;
                        state     <= imuPkg::IdleGap;
                    end

                    imuPkg::IdleGap: begin
                        // Read state adds the last clock of the gap
                        if (idleCount == idleCount_t'(imuPkg::IdleGapCycles - 2)) begin
                            axisIndex <= '0;
                            state     <= imuPkg::Read;
                        end else begin
                            idleCount <= idleCount + 1'b1;
                        end
                    end

                    default: state <= imuPkg::Init;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/i2cTransactionEngine.sv */
`timescale 1ns/1ps
`default_nettype none

module i2cTransactionEngine (
    input  wire         COUNT,
    input  wire         reset_n,
    i2cRequestIf.engine bus,
    input  wire         sdaIn,
    output logic        scl,
    output logic        sdaLow
);

    typedef logic [$clog2(imuPkg::QuarterCycles)-1:0] quarterCount_t;

    imuPkg::busPhase_e phase;
    quarterCount_t     quarterCount;
    logic [1:0]        quarter;      // Position inside one SCL bit
    logic [2:0]        bitCount;
    logic [1:0]        byteIndex;    // 0 address, 1 register, 2 data or read address
    imuPkg::regByte_t  shiftReg;

    logic              tick;
    logic              sampleNow;
    logic              bitDone;
    logic              loadShift;
    imuPkg::regByte_t  loadValue;

    assign tick      = (quarterCount == quarterCount_t'(imuPkg::QuarterCycles - 1));
    assign sampleNow = tick && (quarter == 2'd2);   // Middle of SCL high
    assign bitDone   = tick && (quarter == 2'd3);

    // SCL low for the first half of a bit, high for the second half
    always_comb begin
        case (phase)
            imuPkg::Idle, imuPkg::Start, imuPkg::Finish: scl = 1'b1;
            default:                                      scl = quarter[1];
        endcase
    end

    // Next byte to serialize, picked at the end of the bit before it
    always_comb begin
        loadShift = 1'b0;
        loadValue = {imuPkg::AccelAddr, 1'b0};
        if (bitDone) begin
            case (phase)
                imuPkg::Start: loadShift = 1'b1;
                imuPkg::RepStart: begin
                    loadShift = 1'b1;
                    loadValue = {imuPkg::AccelAddr, 1'b1};   // Address with read bit
                end
                imuPkg::AckBit: begin
                    loadShift = (byteIndex == 2'd0) ||
                                (byteIndex == 2'd1 && !bus.readNotWrite);
                    loadValue = (byteIndex == 2'd0) ? bus.regAddr : bus.writeData;
                end
                default: loadShift = 1'b0;
            endcase
        end
    end

    always_ff @(posedge COUNT) begin
        if (loadShift) begin
            shiftReg <= loadValue;
        end else if (phase == imuPkg::SendByte && bitDone) begin
            shiftReg <= {shiftReg[6:0], 1'b0};
        end else if (phase == imuPkg::ReadByte && sampleNow) begin
            shiftReg <= {shiftReg[6:0], sdaIn};   // MSB arrives first
        end

        if (phase == imuPkg::ReadByte && bitDone && bitCount == 3'd7) begin
            bus.readData <= shiftReg;
        end
    end

    always_ff @(posedge COUNT) begin
        if (!reset_n) begin
            phase        <= imuPkg::Idle;
            quarterCount <= '0;
            quarter      <= '0;
            bitCount     <= '0;
            byteIndex    <= '0;
            sdaLow       <= 1'b0;
            bus.ack      <= 1'b0;
            bus.nack     <= 1'b0;
        end else if (phase == imuPkg::Idle) begin
            quarterCount <= '0;
            quarter      <= '0;
            if (bus.req) begin
                phase     <= imuPkg::Start;
                bitCount  <= '0;
                byteIndex <= '0;
                bus.nack  <= 1'b0;
            end
        end else if (phase == imuPkg::Finish) begin
            // Hold ack until the requester lets go of req
            bus.ack <= 1'b1;
            if (bus.ack && !bus.req) begin
                bus.ack <= 1'b0;
                phase   <= imuPkg::Idle;
            end
        end else begin
            quarterCount <= tick ? '0 : quarterCount + 1'b1;
            if (tick) begin
                quarter <= quarter + 1'b1;
                case (phase)
                    imuPkg::Start: begin
                        if (quarter == 2'd1) sdaLow <= 1'b1;   // SDA falls with SCL high
                        if (quarter == 2'd3) phase <= imuPkg::SendByte;
                    end

                    imuPkg::SendByte: begin
                        // Data moves only in the SCL low half
                        if (quarter == 2'd0) sdaLow <= ~shiftReg[7];
                        if (quarter == 2'd3) begin
                            bitCount <= bitCount + 1'b1;
                            if (bitCount == 3'd7) phase <= imuPkg::AckBit;
                        end
                    end

                    imuPkg::AckBit: begin
                        if (quarter == 2'd0) sdaLow <= 1'b0;
                        if (quarter == 2'd2 && sdaIn) bus.nack <= 1'b1;
                        if (quarter == 2'd3) begin
                            byteIndex <= byteIndex + 1'b1;
                            if (bus.nack) begin
                                phase <= imuPkg::Stop;   // Abort the transaction
                            end else if (byteIndex == 2'd1 && bus.readNotWrite) begin
                                phase <= imuPkg::RepStart;
                            end else if (byteIndex == 2'd2) begin
                                phase <= bus.readNotWrite ? imuPkg::ReadByte : imuPkg::Stop;
                            end else begin
                                phase <= imuPkg::SendByte;
                            end
                        end
                    end

                    imuPkg::RepStart: begin
                        if (quarter == 2'd2) sdaLow <= 1'b1;
                        if (quarter == 2'd3) phase <= imuPkg::SendByte;
                    end

                    imuPkg::ReadByte: begin
                        if (quarter == 2'd3) begin
                            bitCount <= bitCount + 1'b1;
                            if (bitCount == 3'd7) phase <= imuPkg::MasterNack;
                        end
                    end

                    imuPkg::MasterNack: begin
                        if (quarter == 2'd3) phase <= imuPkg::Stop;
                    end

                    imuPkg::Stop: begin
                        if (quarter == 2'd0) sdaLow <= 1'b1;
                        if (quarter == 2'd2) sdaLow <= 1'b0;   // SDA rises with SCL high
                        if (quarter == 2'd3) phase <= imuPkg::Finish;
                    end

                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* logic/i2cRequestIf.sv */
`timescale 1ns/1ps
`default_nettype none

// One register transaction, four-phase req/ack
interface i2cRequestIf;

    logic             req;
    logic             readNotWrite;   // High for a register read
    imuPkg::regByte_t regAddr;
    imuPkg::regByte_t writeData;

    logic             ack;
    imuPkg::regByte_t readData;
    logic             nack;           // Slave failed to acknowledge

    modport requester (
        output req, readNotWrite, regAddr, writeData,
        input  ack, readData, nack
    );

    modport engine (
        input  req, readNotWrite, regAddr, writeData,
        output ack, readData, nack
    );

endinterface

`default_nettype wire

/* logic/imuPkg.sv */
`default_nettype none

package imuPkg;

    // Bus and timing constants
    localparam logic [6:0] AccelAddr     = 7'h1D;   // SDO tied high on the sensor
    localparam int         QuarterCycles = 8;       // COUNT clocks per quarter SCL bit
    localparam int         IdleGapCycles = 200;
    localparam int         InitCount     = 5;
    localparam int         AxisWidth     = 13;

    typedef logic [7:0]           regByte_t;
    typedef logic [AxisWidth-1:0] axisSample_t;

    // Start-up writes in the order they go out on the bus
    localparam regByte_t InitRegs [InitCount] = '{8'h2D, 8'h2D, 8'h2D, 8'h31, 8'h2C};
    localparam regByte_t InitData [InitCount] = '{8'h08, 8'h16, 8'h08, 8'h08, 8'h0F};

    // Low byte first for each axis, X then Y then Z
    localparam regByte_t AxisRegs [6] = '{8'h32, 8'h33, 8'h34, 8'h35, 8'h36, 8'h37};

    typedef enum logic [2:0] {
        Init,       // Raise req for the next start-up write
        InitWait,
        Read,       // Raise req for the next data register
        ReadWait,
        Publish,
        IdleGap
    } seqState_e;

    typedef enum logic [3:0] {
        Idle,
        Start,
        SendByte,
        AckBit,     // Slave drives the acknowledge
        RepStart,
        ReadByte,
        MasterNack, // Master leaves SDA high after the last read bit
        Stop,
        Finish
    } busPhase_e;

endpackage

`default_nettype wire
